// ==== source/core_config.svh ====
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// Data and instruction word
`define WORD_WIDTH    32

// General register file
`define NUM_REGS      16
`define REG_IDX_WIDTH 4

// Instruction memory, one word per address
`define IMEM_DEPTH    64
`define PC_WIDTH      6

// Constant field C of the branch format
`define OFFSET_WIDTH  19

`endif

// ==== source/isaPkg.sv ====
`default_nettype none
`include "core_config.svh"

package isaPkg;

    // Field positions inside the instruction word
    localparam int OpWidth = 5;
    localparam int OpLsb   = 27;   // bits 31..27
    localparam int RaLsb   = 23;   // bits 26..23
    localparam int CondLsb = 19;   // bits 20..19
    localparam int OffLsb  = 0;    // bits 18..0

    typedef logic [`REG_IDX_WIDTH-1:0] regIdxT;
    typedef logic [`OFFSET_WIDTH-1:0]  offsetT;

    // Any code not listed retires as a no-op
    typedef enum logic [OpWidth-1:0] {
        opNop  = 5'b00000,
        opBrch = 5'b10010,
        opHalt = 5'b11011
    } opcodeT;

    // Branch condition on the Ra value
    typedef enum logic [1:0] {
        condZero    = 2'b00,
        condNonZero = 2'b01,
        condPlus    = 2'b10,
        condMinus   = 2'b11
    } condT;

endpackage

`default_nettype wire

// ==== source/corePkg.sv ====
`default_nettype none
`include "core_config.svh"

package corePkg;

    // Datapath word, also the register width
    typedef logic [`WORD_WIDTH-1:0] wordT;

    // PC and instruction memory address
    typedef logic [`PC_WIDTH-1:0] pcT;

    // Fetch sequencer
    // fsIdle  waiting for start
    // fsIssue reading the instruction at pc
    // fsWait  one instruction in flight, waiting for redirect
    typedef enum logic [1:0] {
        fsIdle  = 2'b00,
        fsIssue = 2'b01,
        fsWait  = 2'b10
    } fetchStateT;

endpackage

`default_nettype wire

// ==== source/stageIfs.sv ====
`timescale 1ns/1ps
`default_nettype none

// Decode to condition stage
interface decodeCondIf;
    logic               valid;
    corePkg::pcT        pc;
    corePkg::wordT      regVal;     // Contents of Ra
    isaPkg::condT       cond;
    corePkg::wordT      offset;     // Sign-extended C
    logic               isBranch;
    logic               isHalt;

    modport dcOut (
        output valid, pc, regVal, cond, offset, isBranch, isHalt
    );

    modport ccIn (
        input valid, pc, regVal, cond, offset, isBranch, isHalt
    );
endinterface

// Condition to target stage
interface condTargetIf;
    logic               valid;
    corePkg::pcT        pc;
    corePkg::wordT      offset;
    logic               takeBranch;  // Output of the condition flip-flop
    logic               isHalt;

    modport ccOut (
        output valid, pc, offset, takeBranch, isHalt
    );

    modport tgIn (
        input valid, pc, offset, takeBranch, isHalt
    );
endinterface

`default_nettype wire

// ==== source/fetchStage.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "core_config.svh"

module fetchStage (
    input  logic            clk,
    input  logic            rstN,
    input  logic            start,
    input  logic            imemWrEn,
    input  corePkg::pcT     imemWrAddr,
    input  corePkg::wordT   imemWrData,
    input  logic            redirect,
    input  corePkg::pcT     nextPc,
    input  logic            halt,
    output logic            busy,
    output logic            fetchValid,
    output corePkg::pcT     fetchPc,
    output corePkg::wordT   fetchInstr
);

    corePkg::fetchStateT state;
    corePkg::pcT         pcReg;
    corePkg::wordT       imem [`IMEM_DEPTH];

    // Preload port, only used while idle
    always_ff @(posedge clk) begin
        if (imemWrEn) begin
            imem[imemWrAddr] <= imemWrData;
        end
    end

    // Instruction word and its address travel with fetchValid
    always_ff @(posedge clk) begin
        if (state == corePkg::fsIssue) begin
            fetchInstr <= imem[pcReg];
            fetchPc    <= pcReg;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state      <= corePkg::fsIdle;
            pcReg      <= '0;
            fetchValid <= 1'b0;
        end else begin
            fetchValid <= (state == corePkg::fsIssue);
            case (state)
                corePkg::fsIdle: begin
                    if (start) begin
                        state <= corePkg::fsIssue;
                        pcReg <= '0;            // Every run starts at address 0
                    end
                end
                corePkg::fsIssue: begin
                    state <= corePkg::fsWait;
                end
                corePkg::fsWait: begin
                    if (redirect) begin
                        pcReg <= nextPc;        // Halt address on halt
                        state <= halt ? corePkg::fsIdle : corePkg::fsIssue;
                    end
                end
                default: state <= corePkg::fsIdle;
            endcase
        end
    end

    // Drops together with the done pulse of a halt
    assign busy = (state != corePkg::fsIdle) && !(redirect && halt);

    // A retire only comes back while its instruction is in flight
    assert property (@(posedge clk) disable iff (!rstN)
        redirect |-> state == corePkg::fsWait && !fetchValid);

endmodule

`default_nettype wire

// ==== source/regFile.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "core_config.svh"

module regFile (
    input  logic            clk,
    input  logic            rstN,
    input  logic            wrEn,
    input  isaPkg::regIdxT  wrAddr,
    input  corePkg::wordT   wrData,
    input  isaPkg::regIdxT  rdAddr,
    output corePkg::wordT   rdData
);

    corePkg::wordT regs [`NUM_REGS];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn) begin
            regs[wrAddr] <= wrData;
        end
    end

    // Read sees the value before any write in this cycle
    assign rdData = regs[rdAddr];

endmodule

`default_nettype wire

// ==== source/decodeStage.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "core_config.svh"

module decodeStage (
    input  logic            clk,
    input  logic            rstN,
    input  logic            fetchValid,
    input  corePkg::pcT     fetchPc,
    input  corePkg::wordT   fetchInstr,
    input  corePkg::wordT   rdData,
    output isaPkg::regIdxT  rdAddr,
    decodeCondIf.dcOut      dcOut
);

    isaPkg::opcodeT opcode;
    isaPkg::condT   cond;
    isaPkg::offsetT offField;
    corePkg::wordT  offExt;

    always_comb begin
        opcode   = isaPkg::opcodeT'(fetchInstr[isaPkg::OpLsb +: isaPkg::OpWidth]);
        cond     = isaPkg::condT'(fetchInstr[isaPkg::CondLsb +: 2]);
        offField = fetchInstr[isaPkg::OffLsb +: `OFFSET_WIDTH];
        // Replicate the sign bit of C up to a full word
        offExt   = {{(`WORD_WIDTH - `OFFSET_WIDTH){offField[`OFFSET_WIDTH-1]}}, offField};
    end

    // Ra goes straight to the register file read port
    assign rdAddr = fetchInstr[isaPkg::RaLsb +: `REG_IDX_WIDTH];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            dcOut.valid <= 1'b0;
        end else begin
            dcOut.valid <= fetchValid;
        end
    end

    // Payload loads with the strobe
    always_ff @(posedge clk) begin
        if (fetchValid) begin
            dcOut.pc       <= fetchPc;
            dcOut.regVal   <= rdData;
            dcOut.cond     <= cond;
            dcOut.offset   <= offExt;
            dcOut.isBranch <= (opcode == isaPkg::opBrch);
            dcOut.isHalt   <= (opcode == isaPkg::opHalt);
        end
    end

endmodule

`default_nettype wire

// ==== source/conditionStage.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "core_config.svh"

module conditionStage (
    input  logic            clk,
    input  logic            rstN,
    decodeCondIf.ccIn       ccIn,
    condTargetIf.ccOut      ccOut
);

    logic isZero;
    logic condMet;

    always_comb begin
        isZero = (ccIn.regVal == '0);
        case (ccIn.cond)
            isaPkg::condZero:    condMet = isZero;
            isaPkg::condNonZero: condMet = !isZero;
            isaPkg::condPlus:    condMet = !ccIn.regVal[`WORD_WIDTH-1];
            isaPkg::condMinus:   condMet = ccIn.regVal[`WORD_WIDTH-1];
            default:             condMet = 1'b0;
        endcase
    end

    // Condition flip-flop
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            ccOut.valid      <= 1'b0;
            ccOut.takeBranch <= 1'b0;
        end else begin
            ccOut.valid      <= ccIn.valid;
            ccOut.takeBranch <= ccIn.valid && ccIn.isBranch && condMet;  // No-ops never branch
        end
    end

    always_ff @(posedge clk) begin
        if (ccIn.valid) begin
            ccOut.pc     <= ccIn.pc;
            ccOut.offset <= ccIn.offset;
            ccOut.isHalt <= ccIn.isHalt;
        end
    end

    // Only a valid branch can be taken, never a halt
    assert property (@(posedge clk) disable iff (!rstN)
        ccOut.takeBranch |-> ccOut.valid && !ccOut.isHalt);

endmodule

`default_nettype wire

// ==== source/targetStage.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "core_config.svh"

module targetStage (
    input  logic            clk,
    input  logic            rstN,
    condTargetIf.tgIn       tgIn,
    output logic            redirect,
    output corePkg::pcT     nextPc,
    output logic            halt,
    output logic            retired,
    output logic            taken,
    output logic            done,
    output corePkg::pcT     pc
);

    corePkg::pcT seqPc;
    corePkg::pcT targetPc;
    corePkg::pcT newPc;
    logic        retireQ;
    logic        haltQ;

    always_comb begin
        seqPc    = tgIn.pc + corePkg::pcT'(1);
        // Only the low bits of the offset matter, addresses wrap at 64
        targetPc = seqPc + tgIn.offset[`PC_WIDTH-1:0];
        if (tgIn.isHalt) begin
            newPc = tgIn.pc;                 // Stop on the halt itself
        end else if (tgIn.takeBranch) begin
            newPc = targetPc;
        end else begin
            newPc = seqPc;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            retireQ <= 1'b0;
            haltQ   <= 1'b0;
            taken   <= 1'b0;
            pc      <= '0;
        end else begin
            retireQ <= tgIn.valid;
            haltQ   <= tgIn.valid && tgIn.isHalt;
            taken   <= tgIn.valid && tgIn.takeBranch;
            if (tgIn.valid) begin
                pc <= newPc;                 // Committed pc
            end
        end
    end

    // Every retire redirects fetch, halt tells it to stop
    assign redirect = retireQ;
    assign retired  = retireQ;
    assign halt     = haltQ;
    assign done     = haltQ;
    assign nextPc   = pc;

    // A halt retires and never branches
    assert property (@(posedge clk) disable iff (!rstN)
        done |-> retired && !taken);

endmodule

`default_nettype wire

// ==== source/branchCore.sv ====
`timescale 1ns/1ps
`default_nettype none

module branchCore (
    input  logic            clk,
    input  logic            rstN,
    input  logic            start,
    input  logic            imemWrEn,
    input  corePkg::pcT     imemWrAddr,
    input  corePkg::wordT   imemWrData,
    input  logic            regWrEn,
    input  isaPkg::regIdxT  regWrAddr,
    input  corePkg::wordT   regWrData,
    output logic            busy,
    output logic            retired,
    output logic            taken,
    output logic            done,
    output corePkg::pcT     pc
);

    logic           fetchValid;
    corePkg::pcT    fetchPc;
    corePkg::wordT  fetchInstr;
    isaPkg::regIdxT rdAddr;
    corePkg::wordT  rdData;
    logic           redirect;
    corePkg::pcT    nextPc;
    logic           halt;

    decodeCondIf dcIf ();
    condTargetIf ctIf ();

    fetchStage uFetch (
        .clk        (clk),
        .rstN       (rstN),
        .start      (start),
        .imemWrEn   (imemWrEn),
        .imemWrAddr (imemWrAddr),
        .imemWrData (imemWrData),
        .redirect   (redirect),
        .nextPc     (nextPc),
        .halt       (halt),
        .busy       (busy),
        .fetchValid (fetchValid),
        .fetchPc    (fetchPc),
        .fetchInstr (fetchInstr)
    );

    regFile uRegs (
        .clk    (clk),
        .rstN   (rstN),
        .wrEn   (regWrEn),
        .wrAddr (regWrAddr),
        .wrData (regWrData),
        .rdAddr (rdAddr),
        .rdData (rdData)
    );

    decodeStage uDecode (
        .clk        (clk),
        .rstN       (rstN),
        .fetchValid (fetchValid),
        .fetchPc    (fetchPc),
        .fetchInstr (fetchInstr),
        .rdData     (rdData),
        .rdAddr     (rdAddr),
        .dcOut      (dcIf.dcOut)
    );

    conditionStage uCond (
        .clk   (clk),
        .rstN  (rstN),
        .ccIn  (dcIf.ccIn),
        .ccOut (ctIf.ccOut)
    );

    targetStage uTarget (
        .clk      (clk),
        .rstN     (rstN),
        .tgIn     (ctIf.tgIn),
        .redirect (redirect),
        .nextPc   (nextPc),
        .halt     (halt),
        .retired  (retired),
        .taken    (taken),
        .done     (done),
        .pc       (pc)
    );

endmodule

`default_nettype wire

// ==== tb/tbBranchCore.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "core_config.svh"

module tbBranchCore;

    localparam int NumTests    = 19;
    localparam int ResetCycles = 8;
    localparam int RetireGap   = 5;    // Issue after redirect, then four stages
    // Memory fill and preload, then up to 40 run cycles per test
    localparam int CycleLimit  = ResetCycles + 16 + NumTests * (40 + `IMEM_DEPTH + 8);

    typedef struct packed {
        logic        lead;         // Nop at 0, instruction under test at 1
        logic        pokeStart;    // Extra start pulse while busy
        logic        isRand;       // Register value from the LFSR
        logic [4:0]  op;
        logic [3:0]  ra;
        logic [1:0]  cond;
        logic [18:0] off;
        logic [31:0] regVal;
        logic [5:0]  expPc;        // pc after the instruction retires
        logic        expTaken;
    } testT;

    logic           clk;
    logic           rstN;
    logic           start;
    logic           imemWrEn;
    corePkg::pcT    imemWrAddr;
    corePkg::wordT  imemWrData;
    logic           regWrEn;
    isaPkg::regIdxT regWrAddr;
    corePkg::wordT  regWrData;
    logic           busy;
    logic           retired;
    logic           taken;
    logic           done;
    corePkg::pcT    pc;

    testT        tests [NumTests];
    int          numLoaded;
    logic [31:0] lfsrState;
    int          errors;
    int          failedTests;
    int          cycleCount;

    branchCore uut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Run limit
    initial begin
        cycleCount = 0;
        while (cycleCount < CycleLimit) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("Timeout: no done after %0d cycles", CycleLimit);
        $display("sim failed");
        $finish;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic drawWord(output logic [31:0] val);
        val = '0;
        for (int i = 0; i < 32; i++) begin
            lfsrState = lfsrStep(lfsrState);
            val = {val[30:0], lfsrState[0]};    // One step per bit
        end
    endtask

    function automatic logic condHolds(input logic [1:0] cond, input logic [31:0] val);
        case (isaPkg::condT'(cond))
            isaPkg::condZero:    return val == 32'd0;
            isaPkg::condNonZero: return val != 32'd0;
            isaPkg::condPlus:    return !val[31];
            default:             return val[31];
        endcase
    endfunction

    // Bits 22..21 are unused by the branch format
    function automatic logic [31:0] encode(input logic [4:0] op, input logic [3:0] ra,
                                           input logic [1:0] cond, input logic [18:0] off);
        return {op, ra, 2'b00, cond, off};
    endfunction

    function automatic void addTest(input int lead, input int poke, input int rnd,
                                    input logic [4:0] op, input int ra, input logic [1:0] cond,
                                    input int off, input logic [31:0] val, input int expPc,
                                    input int expTaken);
        testT t;
        t.lead      = (lead != 0);
        t.pokeStart = (poke != 0);
        t.isRand    = (rnd != 0);
        t.op        = op;
        t.ra        = 4'(ra);
        t.cond      = cond;
        t.off       = 19'(off);             // Negative offsets wrap into the field
        t.regVal    = val;
        t.expPc     = 6'(expPc);
        t.expTaken  = (expTaken != 0);
        tests[numLoaded] = t;
        numLoaded++;
    endfunction

    task automatic loadTable();
        numLoaded = 0;
        addTest(0, 0, 0, isaPkg::opBrch, 3, isaPkg::condZero, 5, 32'h0, 6, 1);
        addTest(0, 0, 0, isaPkg::opBrch, 3, isaPkg::condZero, 5, 32'h7, 1, 0);
        addTest(0, 0, 0, isaPkg::opBrch, 5, isaPkg::condNonZero, 9, 32'h10, 10, 1);
        addTest(0, 0, 0, isaPkg::opBrch, 5, isaPkg::condNonZero, 9, 32'h0, 1, 0);
        addTest(0, 0, 0, isaPkg::opBrch, 1, isaPkg::condPlus, 20, 32'h7fff_ffff, 21, 1);
        addTest(0, 0, 0, isaPkg::opBrch, 1, isaPkg::condPlus, 20, 32'h8000_0000, 1, 0);
        addTest(0, 0, 0, isaPkg::opBrch, 15, isaPkg::condMinus, 30, 32'hffff_fff0, 31, 1);
        addTest(0, 0, 0, isaPkg::opBrch, 15, isaPkg::condMinus, 30, 32'h1, 1, 0);
        addTest(0, 0, 0, isaPkg::opBrch, 9, isaPkg::condMinus, -3, 32'h8000_0001, 62, 1);
        // Expected values of random entries follow from the drawn value
        addTest(0, 0, 1, isaPkg::opBrch, 2, isaPkg::condZero, 12, 32'h0, 0, 0);
        addTest(0, 0, 1, isaPkg::opBrch, 4, isaPkg::condNonZero, 40, 32'h0, 0, 0);
        addTest(0, 0, 1, isaPkg::opBrch, 6, isaPkg::condPlus, 25, 32'h0, 0, 0);
        addTest(0, 0, 1, isaPkg::opBrch, 8, isaPkg::condMinus, 50, 32'h0, 0, 0);
        addTest(0, 0, 0, 5'b00101, 0, isaPkg::condZero, 7, 32'h0, 1, 0);
        addTest(0, 0, 0, isaPkg::opNop, 0, isaPkg::condZero, 7, 32'h0, 1, 0);
        addTest(0, 0, 0, isaPkg::opHalt, 0, isaPkg::condZero, 3, 32'h0, 0, 0);
        addTest(1, 0, 0, isaPkg::opBrch, 7, isaPkg::condNonZero, 4, 32'h3, 6, 1);
        addTest(0, 1, 0, isaPkg::opBrch, 10, isaPkg::condZero, 7, 32'h0, 8, 1);
        addTest(1, 0, 0, isaPkg::opBrch, 11, isaPkg::condPlus, -3, 32'h5, 63, 1);
    endtask

    task automatic checkEq(input int got, input int exp, input string what);
        assert (got == exp) else begin
            $display("FAIL %0t: %s is %0d, expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic reportResult(input string name, input int errorsBefore);
        if (errors == errorsBefore) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: failed with %0d errors", name, errors - errorsBefore);
            failedTests++;
        end
    endtask

    task automatic checkIdle();
        int errorsBefore;
        errorsBefore = errors;
        repeat (5) begin
            @(negedge clk);
            checkEq(int'(busy), 0, "busy before start");
            checkEq(int'(retired), 0, "retired before start");
            checkEq(int'(taken), 0, "taken before start");
            checkEq(int'(done), 0, "done before start");
            checkEq(int'(pc), 0, "pc before start");
        end
        reportResult("idle after reset", errorsBefore);
    endtask

    task automatic runTest(input int idx);
        testT          t;
        logic [31:0]   val;
        logic          expTaken;
        corePkg::pcT   expPc;
        corePkg::pcT   finalPc;
        logic          isHalt;
        logic          sawDone;
        int            addr;
        int            offInt;
        int            expRetires;
        int            retires;
        int            cyc;
        int            lastRetire;
        int            errorsBefore;

        t = tests[idx];
        errorsBefore = errors;
        addr     = t.lead ? 1 : 0;
        val      = t.regVal;
        expTaken = t.expTaken;
        expPc    = t.expPc;
        if (t.isRand) begin
            drawWord(val);
            expTaken = condHolds(t.cond, val);
            offInt   = int'($signed(t.off));
            // Target is addr + 1 + C, modulo the memory depth
            expPc = corePkg::pcT'(((addr + 1 + (expTaken ? offInt : 0)) % `IMEM_DEPTH
                                   + `IMEM_DEPTH) % `IMEM_DEPTH);
        end
        isHalt     = (t.op == isaPkg::opHalt);
        finalPc    = isHalt ? corePkg::pcT'(addr) : expPc;
        expRetires = addr + (isHalt ? 1 : 2);

        for (int a = 0; a < `IMEM_DEPTH; a++) begin
            @(posedge clk);
            imemWrEn   <= 1'b1;
            imemWrAddr <= corePkg::pcT'(a);
            imemWrData <= encode(isaPkg::opHalt, '0, '0, 19'(a));  // Halt tagged with its address
        end
        if (t.lead) begin
            @(posedge clk);
            imemWrAddr <= '0;
            imemWrData <= encode(isaPkg::opNop, '0, '0, '0);
        end
        @(posedge clk);
        imemWrAddr <= corePkg::pcT'(addr);
        imemWrData <= encode(t.op, t.ra, t.cond, t.off);
        @(posedge clk);
        imemWrEn  <= 1'b0;
        regWrEn   <= 1'b1;
        regWrAddr <= t.ra;
        regWrData <= val;
        @(posedge clk);
        regWrEn <= 1'b0;
        start   <= 1'b1;
        @(posedge clk);
        start <= 1'b0;

        retires    = 0;
        cyc        = 0;
        lastRetire = 0;
        sawDone    = 1'b0;
        while (!sawDone) begin
            @(posedge clk);
            start <= (t.pokeStart && cyc == 2);    // Ignored while busy
            @(negedge clk);
            cyc++;
            if (retired) begin
                if (retires > 0) begin
                    checkEq(cyc - lastRetire, RetireGap, "cycles between retires");
                end
                if (retires == addr) begin
                    checkEq(int'(taken), int'(expTaken), "taken");
                    checkEq(int'(pc), int'(expPc), "pc after the instruction");
                end else if (!done) begin
                    checkEq(int'(taken), 0, "taken on the leading no-op");
                    checkEq(int'(pc), 1, "pc after the leading no-op");
                end
                if (!done) begin
                    checkEq(int'(busy), 1, "busy during the run");
                end
                lastRetire = cyc;
                retires++;
            end
            if (done) begin
                sawDone = 1'b1;
                checkEq(int'(pc), int'(finalPc), "final pc");
                checkEq(int'(busy), 0, "busy with done");
                checkEq(int'(retired), 1, "retired with done");
            end
        end
        checkEq(retires, expRetires, "retire count");
        reportResult($sformatf("test %0d", idx), errorsBefore);
    endtask

    initial begin
        rstN        = 1'b0;
        start       = 1'b0;
        imemWrEn    = 1'b0;
        imemWrAddr  = '0;
        imemWrData  = '0;
        regWrEn     = 1'b0;
        regWrAddr   = '0;
        regWrData   = '0;
        errors      = 0;
        failedTests = 0;
        lfsrState   = 32'hb07a_8a8e;
        loadTable();
        repeat (ResetCycles) @(posedge clk);
        rstN <= 1'b1;
        checkIdle();
        for (int i = 0; i < NumTests; i++) begin
            runTest(i);
        end
        $display("%0d of %0d tests failed, %0d check errors", failedTests, NumTests + 1,
                 errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+source
source/isaPkg.sv
source/corePkg.sv
source/stageIfs.sv
source/fetchStage.sv
source/regFile.sv
source/decodeStage.sv
source/conditionStage.sv
source/targetStage.sv
source/branchCore.sv
tb/tbBranchCore.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Verilator build and run of the branch core testbench
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tbBranchCore -f all.f -o tbBranchCore \
    && ./obj_dir/tbBranchCore > sim.log 2>&1 \
    || echo "build or simulation error" >> sim.log

cat sim.log
grep -qx "sim passed" sim.log && exit 0 || exit 1
